/* tb.f */
spi_pkg.sv
spi_regs.sv
serial_clock_generator.sv
spi_master.sv
spi_top.sv
tb_clock.sv
spi_slave_model.sv
tb_spi.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the SPI testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_spi -f tb.f -o tb_spi_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_spi_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

/* tb_spi.sv */
// ----------------------------------------------------------------------
// Testbench top for the SPI master peripheral. Drives the host strobes,
// talks to a slave model and checks data, status and sck timing.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_spi import spi_pkg::*; ();

    localparam int PERIOD_NS   = 20;
    localparam int MAX_DIV     = 7;
    localparam int NUM_XFERS   = 10;
    localparam int XFER_CYCLES = 40 + 17 * (MAX_DIV + 1);  // transfer plus status polls
    localparam int WATCHDOG_NS = (NUM_XFERS * XFER_CYCLES + 600) * PERIOD_NS;

    logic      clk;
    logic      rst_n;
    logic      wr_en;
    logic      rd_en;
    logic      miso;
    logic      ss;
    logic      sck;
    logic      mosi;
    reg_addr_t addr;
    byte_t     wr_data;
    byte_t     rd_data;
    logic      cur_cpol;
    logic      cur_cpha;
    div_t      cur_div;
    byte_t     slave_tx;
    byte_t     slave_rx;
    int        slave_xfers;
    int        errors;
    int        checks;
    int        tests;
    logic      ss_seen      = 1'b1;  // sck monitor state
    logic      mon_idle_level;
    int        mon_edges    = 0;
    int        mon_bad_idle = 0;
    int        mon_min      = 0;
    int        mon_max      = 0;
    int        mon_gap;
    time       mon_last;

    tb_clock clk_gen (.clk(clk));

    spi_top spi_top_inst (
        .clk,
        .rst_n,
        .wr_en,
        .rd_en,
        .miso,
        .addr,
        .wr_data,
        .rd_data,
        .ss,
        .sck,
        .mosi
    );

    spi_slave_model slave (
        .ss,
        .sck,
        .mosi,
        .cpol       (cur_cpol),
        .cpha       (cur_cpha),
        .tx_byte    (slave_tx),
        .miso,
        .rx_byte    (slave_rx),
        .xfer_count (slave_xfers)
    );

    // records sck level and edge spacing around each slave select
    always @(ss or sck) begin
        if (rst_n === 1'b1) begin
            if (ss !== ss_seen) begin
                if (ss === 1'b0) begin
                    mon_idle_level = sck;
                    mon_edges      = 0;
                    mon_last       = $time;
                    mon_min        = 32'h7fff_ffff;
                    mon_max        = 0;
                end
            end else if (ss === 1'b1) begin
                if (sck !== cur_cpol)
                    mon_bad_idle = mon_bad_idle + 1;
            end else begin
                mon_gap   = int'($time - mon_last);
                mon_last  = $time;
                mon_edges = mon_edges + 1;
                if (mon_gap < mon_min)
                    mon_min = mon_gap;
                if (mon_gap > mon_max)
                    mon_max = mon_gap;
            end
        end
        ss_seen = ss;
    end

    function automatic byte_t expected_status(input logic busy, input logic rx_ready,
                                              input logic overrun);
        byte_t s;
        s                    = '0;
        s[STAT_BUSY_BIT]     = busy;
        s[STAT_RX_READY_BIT] = rx_ready;
        s[STAT_OVERRUN_BIT]  = overrun;
        return s;
    endfunction

    function automatic byte_t mode_word(input logic cpol, input logic cpha);
        byte_t w;
        w                = '0;
        w[CTRL_CPOL_BIT] = cpol;
        w[CTRL_CPHA_BIT] = cpha;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input byte_t d);
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output byte_t d);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        d     = rd_data;  // registered, valid one cycle after the strobe
    endtask

    task automatic set_mode(input logic cpol, input logic cpha);
        write_reg(ADDR_CTRL, mode_word(cpol, cpha));
        cur_cpol = cpol;
        cur_cpha = cpha;
    endtask

    task automatic set_divider(input div_t d);
        write_reg(ADDR_DIV, d);
        cur_div = d;
    endtask

    task automatic wait_idle(output byte_t status);
        int polls;
        polls = 0;
        read_reg(ADDR_STATUS, status);
        while (status[STAT_BUSY_BIT] && polls < XFER_CYCLES) begin
            read_reg(ADDR_STATUS, status);
            polls++;
        end
        if (status[STAT_BUSY_BIT]) begin
            errors++;
            $display("transfer did not finish within %0d status reads", XFER_CYCLES);
        end
    endtask

    // one byte each way; poke_busy adds a busy read and a write that must be dropped
    task automatic run_transfer(input byte_t mb, input byte_t sb, input logic exp_overrun,
                                input logic poke_busy);
        byte_t status;
        int    xfers_before;
        slave_tx     = sb;
        xfers_before = slave_xfers;
        write_reg(ADDR_DATA, mb);
        if (poke_busy) begin
            write_reg(ADDR_DATA, ~mb);  // lands while the start is still pending
            read_reg(ADDR_STATUS, status);
            check_value("status busy bit", status[STAT_BUSY_BIT], 1);
        end
        wait_idle(status);
        check_value("status after transfer", status, expected_status(1'b0, 1'b1, exp_overrun));
        check_value("slave rx byte", slave_rx, mb);
        check_value("slave transfer count", slave_xfers, xfers_before + 1);
        check_value("sck edges per transfer", mon_edges, 16);
        check_value("sck idle level at ss fall", mon_idle_level, cur_cpol);
        check_value("sck shortest half period ns", mon_min, (cur_div + 1) * PERIOD_NS);
        check_value("sck longest half period ns", mon_max, (cur_div + 1) * PERIOD_NS);
        check_value("sck moves while ss high", mon_bad_idle, 0);
    endtask

    task automatic check_data(input byte_t sb);
        byte_t d;
        read_reg(ADDR_DATA, d);
        check_value("rd_data of data register", d, sb);
        read_reg(ADDR_STATUS, d);
        check_value("status after data read", d, expected_status(1'b0, 1'b0, 1'b0));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
    endtask

    initial begin
        byte_t d;
        byte_t mb;
        byte_t sb;
        int    e0;
        void'($urandom(32'h9cf5a0b7));
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        addr     = ADDR_CTRL;
        wr_data  = '0;
        cur_cpol = 1'b0;
        cur_cpha = 1'b0;
        cur_div  = DIV_RESET;
        slave_tx = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        e0 = errors;
        read_reg(ADDR_DIV, d);
        check_value("divider after reset", d, DIV_RESET);
        read_reg(ADDR_STATUS, d);
        check_value("status after reset", d, expected_status(1'b0, 1'b0, 1'b0));
        for (int m = 0; m < 4; m++) begin
            set_mode(m[0], m[1]);
            read_reg(ADDR_CTRL, d);
            check_value("control readback", d, mode_word(m[0], m[1]));
            mb = 8'($urandom);
            set_divider(mb);
            read_reg(ADDR_DIV, d);
            check_value("divider readback", d, mb);
        end
        finish_test("register readback", e0);

        e0 = errors;
        for (int m = 0; m < 4; m++) begin
            set_mode(m[0], m[1]);
            set_divider(div_t'($urandom % (MAX_DIV + 1)));
            mb = 8'($urandom);
            sb = 8'($urandom);
            run_transfer(mb, sb, 1'b0, 1'b0);
            check_data(sb);
        end
        finish_test("full duplex in four modes", e0);

        e0 = errors;
        set_mode(1'b1, 1'b0);
        repeat (2) @(negedge clk);
        check_value("sck idle with cpol 1", sck, 1'b1);
        check_value("ss idle", ss, 1'b1);
        set_mode(1'b0, 1'b0);
        repeat (2) @(negedge clk);
        check_value("sck idle with cpol 0", sck, 1'b0);
        check_value("sck moves while ss high", mon_bad_idle, 0);
        finish_test("sck idle level", e0);

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            set_divider(div_t'($urandom % (MAX_DIV + 1)));
            mb = 8'($urandom);
            sb = 8'($urandom);
            run_transfer(mb, sb, 1'b0, 1'b0);
            check_data(sb);
        end
        finish_test("divider timing", e0);

        e0 = errors;
        set_divider(div_t'($urandom % (MAX_DIV + 1)));
        mb = 8'($urandom);
        sb = 8'($urandom);
        run_transfer(mb, sb, 1'b0, 1'b1);
        check_data(sb);
        run_transfer(8'($urandom), 8'($urandom), 1'b0, 1'b0);
        mb = 8'($urandom);
        sb = 8'($urandom);
        run_transfer(mb, sb, 1'b1, 1'b0);  // second byte unread sets overrun
        check_data(sb);
        finish_test("status flags", e0);

        $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* spi_slave_model.sv */
// ----------------------------------------------------------------------
// Behavioral SPI slave for the testbench. Answers each transfer with a
// preset byte MSB first in the given mode and keeps the byte it got.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model import spi_pkg::*; (
    input  logic  ss,
    input  logic  sck,
    input  logic  mosi,
    input  logic  cpol,
    input  logic  cpha,
    input  byte_t tx_byte,
    output logic  miso,
    output byte_t rx_byte,
    output int    xfer_count
);

    logic  ss_seen    = 1'b1;
    logic  miso_q     = 1'b0;
    byte_t tx_shift   = '0;
    byte_t rx_shift   = '0;
    byte_t rx_last    = '0;
    int    bits_in    = 0;
    int    xfers_seen = 0;

    assign miso       = miso_q;
    assign rx_byte    = rx_last;
    assign xfer_count = xfers_seen;

    always @(ss or sck) begin
        if (ss !== ss_seen) begin
            if (ss === 1'b0) begin  // slave selected
                xfers_seen = xfers_seen + 1;
                bits_in    = 0;
                rx_shift   = '0;
                tx_shift   = tx_byte;
                if (!cpha) begin
                    miso_q   = tx_shift[7];  // first bit out before the first edge
                    tx_shift = {tx_shift[6:0], 1'b0};
                end
            end
        end else if (ss === 1'b0) begin
            // leading edge leaves the idle level, cpha picks the sample edge
            if ((sck != cpol) != cpha) begin
                rx_shift = {rx_shift[6:0], mosi};
                bits_in  = bits_in + 1;
                if (bits_in == 8)
                    rx_last = rx_shift;
            end else begin
                miso_q   = tx_shift[7];
                tx_shift = {tx_shift[6:0], 1'b0};
            end
        end
        ss_seen = ss;
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
// ----------------------------------------------------------------------
// Free-running clock source for the SPI testbench, 20 ns period.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 10;

    initial clk = 1'b0;
    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

/* spi_top.sv */
// ----------------------------------------------------------------------
// Top level of the SPI master peripheral. Joins the host register block
// to the transfer engine and brings out the SPI pins.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_top import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  logic      rd_en,
    input  logic      miso,
    input  reg_addr_t addr,
    input  byte_t     wr_data,
    output byte_t     rd_data,
    output logic      ss,
    output logic      sck,
    output logic      mosi
);

    logic  tx_data_valid;
    logic  cpol;
    logic  cpha;
    logic  clk_divider_valid;
    logic  busy;
    logic  rx_data_valid;
    byte_t tx_data;
    byte_t rx_data;
    div_t  clk_divider;

    spi_regs u_spi_regs (
        .clk,
        .rst_n,
        .wr_en,
        .rd_en,
        .addr,
        .wr_data,
        .rd_data,
        .busy,
        .rx_data_valid,
        .rx_data,
        .tx_data_valid,
        .tx_data,
        .cpol,
        .cpha,
        .clk_divider_valid,
        .clk_divider
    );

    spi_master u_spi_master (
        .clk,
        .rst_n,
        .tx_data_valid,
        .miso,
        .cpol,
        .cpha,
        .clk_divider_valid,
        .tx_data,
        .clk_divider,
        .ss,
        .sck,
        .mosi,
        .busy,
        .rx_data_valid,
        .rx_data
    );

endmodule

`default_nettype wire

/* spi_master.sv */
// ----------------------------------------------------------------------
// SPI master transfer engine. A start pulse sends one byte MSB first on
// mosi while the byte on miso is shifted in, in any of the four SPI
// modes. The received byte is presented with a one-cycle valid pulse.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_master import spi_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_data_valid,
    input  logic  miso,
    input  logic  cpol,
    input  logic  cpha,
    input  logic  clk_divider_valid,
    input  byte_t tx_data,
    input  div_t  clk_divider,
    output logic  ss,
    output logic  sck,
    output logic  mosi,
    output logic  busy,
    output logic  rx_data_valid,
    output byte_t rx_data
);

    spi_state_t state;
    spi_state_t state_nxt;
    logic [3:0] bit_cnt;          // leading edges seen in ACTIVE
    logic [3:0] bit_cnt_nxt;
    logic       mode_cpol;        // mode held for the whole transfer
    logic       mode_cpha;
    logic       sck_en;
    logic       sck_en_nxt;
    logic       leading_edge;
    logic       trailing_edge;
    logic       shift_edge;
    logic       sample_edge;
    logic       ss_nxt;
    logic       sck_nxt;
    logic       mosi_nxt;
    logic       rx_data_valid_nxt;
    byte_t      tx_shift;
    byte_t      tx_shift_nxt;
    byte_t      rx_shift;
    byte_t      rx_shift_nxt;
    byte_t      rx_data_nxt;

    serial_clock_generator u_sck_gen (
        .clk,
        .rst_n,
        .en                (sck_en),
        .clk_divider_valid,
        .clk_divider,
        .leading_edge,
        .trailing_edge
    );

    // cpha 0 samples on leading edges, cpha 1 on trailing edges
    assign shift_edge  = mode_cpha ? leading_edge : trailing_edge;
    assign sample_edge = mode_cpha ? trailing_edge : leading_edge;
    assign busy        = (state != IDLE);

    always_comb begin
        state_nxt         = state;
        bit_cnt_nxt       = bit_cnt;
        ss_nxt            = ss;
        sck_nxt           = sck;
        mosi_nxt          = mosi;
        sck_en_nxt        = sck_en;
        rx_data_valid_nxt = 1'b0;
        tx_shift_nxt      = tx_shift;
        rx_shift_nxt      = rx_shift;
        rx_data_nxt       = rx_data;

        case (state)
            IDLE: begin
                sck_nxt = cpol;  // sck follows the idle level
                if (tx_data_valid)
                    state_nxt = START;
            end
            START: begin
                ss_nxt       = 1'b0;
                sck_en_nxt   = 1'b1;
                bit_cnt_nxt  = '0;
                tx_shift_nxt = tx_data;
                if (!mode_cpha) begin
                    mosi_nxt     = tx_data[7];  // first bit valid before first edge
                    tx_shift_nxt = {tx_data[6:0], 1'b0};
                end
                state_nxt = ACTIVE;
            end
            ACTIVE: begin
                if (leading_edge) begin
                    sck_nxt     = ~mode_cpol;
                    bit_cnt_nxt = bit_cnt + 1'b1;
                end else if (trailing_edge) begin
                    sck_nxt = mode_cpol;
                end
                if (shift_edge) begin
                    mosi_nxt     = tx_shift[7];
                    tx_shift_nxt = {tx_shift[6:0], 1'b0};
                end
                if (sample_edge)
                    rx_shift_nxt = {rx_shift[6:0], miso};
                if (trailing_edge && bit_cnt == 4'd8) begin
                    rx_data_nxt       = rx_shift_nxt;  // includes the last sample
                    rx_data_valid_nxt = 1'b1;
                    bit_cnt_nxt       = '0;
                    state_nxt         = STOP;
                end
            end
            STOP: begin
                if (leading_edge) begin
                    ss_nxt     = 1'b1;
                    sck_en_nxt = 1'b0;
                    state_nxt  = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            bit_cnt       <= '0;
            ss            <= 1'b1;
            sck           <= 1'b0;
            mosi          <= 1'b0;
            sck_en        <= 1'b0;
            rx_data_valid <= 1'b0;
            mode_cpol     <= 1'b0;
            mode_cpha     <= 1'b0;
        end else begin
            state         <= state_nxt;
            bit_cnt       <= bit_cnt_nxt;
            ss            <= ss_nxt;
            sck           <= sck_nxt;
            mosi          <= mosi_nxt;
            sck_en        <= sck_en_nxt;
            rx_data_valid <= rx_data_valid_nxt;
            if (state == IDLE) begin
                mode_cpol <= cpol;
                mode_cpha <= cpha;
            end
        end
    end

    always_ff @(posedge clk) begin
        tx_shift <= tx_shift_nxt;
        rx_shift <= rx_shift_nxt;
        rx_data  <= rx_data_nxt;
    end

    // the slave stays selected for every bit of the byte
    a_ss_low_active : assert property (
        @(posedge clk) disable iff (!rst_n) (state == ACTIVE) |-> !ss);

endmodule

`default_nettype wire

/* serial_clock_generator.sv */
// ----------------------------------------------------------------------
// Edge pulse generator for the SPI clock. While enabled it emits
// leading and trailing edge pulses in turn, one every div+1 clk cycles,
// beginning with a leading edge.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module serial_clock_generator import spi_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic clk_divider_valid,
    input  div_t clk_divider,
    output logic leading_edge,
    output logic trailing_edge
);

    div_t divider;    // latched divider value
    div_t count;      // cycles left until the next edge
    logic phase;      // 0: next edge is leading
    logic edge_due;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            divider <= DIV_RESET;
        else if (clk_divider_valid)
            divider <= clk_divider;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= DIV_RESET;
            phase <= 1'b0;
        end else if (!en) begin
            count <= divider;  // restart cleanly for the next transfer
            phase <= 1'b0;
        end else if (count == '0) begin
            count <= divider;
            phase <= ~phase;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign edge_due      = en && (count == '0);
    assign leading_edge  = edge_due && !phase;
    assign trailing_edge = edge_due && phase;

    a_single_edge : assert property (
        @(posedge clk) disable iff (!rst_n) !(leading_edge && trailing_edge));

endmodule

`default_nettype wire

/* spi_regs.sv */
// ----------------------------------------------------------------------
// Host register block of the SPI master. Decodes write and read strobes,
// holds mode, divider and data registers and the status flags, and
// issues the start pulse toward the transfer engine.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spi_regs import spi_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  logic      rd_en,
    input  reg_addr_t addr,
    input  byte_t     wr_data,
    output byte_t     rd_data,
    input  logic      busy,
    input  logic      rx_data_valid,
    input  byte_t     rx_data,
    output logic      tx_data_valid,
    output byte_t     tx_data,
    output logic      cpol,
    output logic      cpha,
    output logic      clk_divider_valid,
    output div_t      clk_divider
);

    logic  start_pending;  // start issued, master not yet busy
    logic  rx_ready;
    logic  overrun;
    logic  start_ok;
    logic  rd_data_clr;
    byte_t rx_byte;
    byte_t ctrl_word;
    byte_t status_word;

    assign start_ok    = wr_en && (addr == ADDR_DATA) && !busy && !start_pending;
    assign rd_data_clr = rd_en && (addr == ADDR_DATA);

    always_comb begin
        ctrl_word                = '0;
        ctrl_word[CTRL_CPOL_BIT] = cpol;
        ctrl_word[CTRL_CPHA_BIT] = cpha;
    end

    always_comb begin
        status_word                    = '0;
        status_word[STAT_BUSY_BIT]     = busy || start_pending;
        status_word[STAT_RX_READY_BIT] = rx_ready;
        status_word[STAT_OVERRUN_BIT]  = overrun;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpol              <= 1'b0;
            cpha              <= 1'b0;
            clk_divider       <= DIV_RESET;
            clk_divider_valid <= 1'b0;
            tx_data_valid     <= 1'b0;
            start_pending     <= 1'b0;
            rx_ready          <= 1'b0;
            overrun           <= 1'b0;
            rd_data           <= '0;
        end else begin
            clk_divider_valid <= wr_en && (addr == ADDR_DIV);
            tx_data_valid     <= start_ok;  // writes while busy are dropped
            if (wr_en && addr == ADDR_CTRL) begin
                cpol <= wr_data[CTRL_CPOL_BIT];
                cpha <= wr_data[CTRL_CPHA_BIT];
            end
            if (wr_en && addr == ADDR_DIV)
                clk_divider <= wr_data;
            if (start_ok)
                start_pending <= 1'b1;
            else if (busy)
                start_pending <= 1'b0;  // master has taken over
            if (rx_data_valid) begin
                rx_ready <= 1'b1;
                overrun  <= (rx_ready || overrun) && !rd_data_clr;
            end else if (rd_data_clr) begin
                rx_ready <= 1'b0;
                overrun  <= 1'b0;
            end
            if (rd_en) begin
                case (addr)
                    ADDR_CTRL: rd_data <= ctrl_word;
                    ADDR_DIV:  rd_data <= clk_divider;
                    ADDR_DATA: rd_data <= rx_byte;
                    default:   rd_data <= status_word;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok)
            tx_data <= wr_data;
        if (rx_data_valid)
            rx_byte <= rx_data;
    end

    // a start never reaches the master while it is running
    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n) tx_data_valid |-> !busy);

endmodule

`default_nettype wire

/* spi_pkg.sv */
// ----------------------------------------------------------------------
// Shared types and constants of the SPI master peripheral.
// Modules pull these in with a wildcard import in their header.
// ----------------------------------------------------------------------
`default_nettype none

package spi_pkg;

    typedef logic [7:0] byte_t;      // data byte on the bus and the wire
    typedef logic [7:0] div_t;       // sck half period is div+1 clk cycles
    typedef logic [1:0] reg_addr_t;  // host register address

    // register map
    localparam reg_addr_t ADDR_CTRL   = 2'd0;
    localparam reg_addr_t ADDR_DIV    = 2'd1;
    localparam reg_addr_t ADDR_DATA   = 2'd2;
    localparam reg_addr_t ADDR_STATUS = 2'd3;

    // control register fields
    localparam int CTRL_CPOL_BIT = 0;
    localparam int CTRL_CPHA_BIT = 1;

    // status register fields
    localparam int STAT_BUSY_BIT     = 0;
    localparam int STAT_RX_READY_BIT = 1;
    localparam int STAT_OVERRUN_BIT  = 2;

    localparam div_t DIV_RESET = 8'd3;  // divider out of reset

    typedef enum logic [1:0] {
        IDLE,
        START,
        ACTIVE,
        STOP
    } spi_state_t;

endpackage

`default_nettype wire
